/* async_fifo.f */
fifo_pkg.sv
dualport_ram_async.sv
gray_ptr_sync.sv
fifo_wr_ctrl.sv
fifo_rd_ctrl.sv
async_fifo.sv
tb_async_fifo.sv

/* Makefile */
# Verilator build and run for the async FIFO testbench

VERILATOR ?= verilator
TOP       ?= tb_async_fifo
FILELIST  ?= async_fifo.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Result is decided by the pass line in the log
run: compile
	./$(BIN) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_async_fifo.sv */
`timescale 1ns/1ps

module tb_async_fifo;

  import fifo_pkg::*;

  logic  wr_clk = 1'b0;
  logic  rd_clk = 1'b0;
  logic  rst_n;
  logic  wr_en;
  logic  rd_en;
  data_t wr_data;
  data_t rd_data;
  logic  full;
  logic  empty;
  logic  afull;
  logic  aempty;

  integer seed = 32'h6882;
  integer rd_seed;              // Read strobes get their own stream

  data_t model [$];             // Words written but not yet read
  data_t rd_expect;
  data_t last_read;
  bit    rd_pending = 1'b0;     // A read result is due at the next rd_clk negedge
  int    rd_count = 0;
  int    errors = 0;
  int    checks = 0;
  string cur_test;

  always #20 wr_clk = ~wr_clk;
  always #28 rd_clk = ~rd_clk;  // Drifts against wr_clk

  async_fifo dut0 (
    .wr_clk  (wr_clk ),
    .rd_clk  (rd_clk ),
    .rst_n   (rst_n  ),
    .wr_en   (wr_en  ),
    .rd_en   (rd_en  ),
    .wr_data (wr_data),
    .rd_data (rd_data),
    .full    (full   ),
    .empty   (empty  ),
    .afull   (afull  ),
    .aempty  (aempty )
  );

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("CHECK FAILED %s %s: expected %0h, actual %0h", cur_test, what,
               expected, actual);
      errors++;
    end
  endtask

  function automatic logic flag_now(input string flag);
    if (flag == "full") return full;
    else if (flag == "afull") return afull;
    else if (flag == "empty") return empty;
    else return aempty;
  endfunction

  // Polls on the falling edge of the flag's own clock
  task automatic wait_flag(input string flag, input logic value, input int limit);
    int n;
    n = 0;
    while (flag_now(flag) !== value && n < limit) begin
      if (flag == "full" || flag == "afull") @(negedge wr_clk);
      else @(negedge rd_clk);
      n++;
    end
    if (flag_now(flag) !== value) begin
      $display("Timeout in %s: %s did not reach %0b within %0d cycles", cur_test, flag,
               value, limit);
      errors++;
    end
  endtask

  // Called at a wr_clk negedge, full is stable until the next posedge
  task automatic put_write(input logic en, input data_t value);
    wr_en   = en;
    wr_data = value;
    if (en && !full) begin
      model.push_back(value);
    end
  endtask

  // Called at a rd_clk negedge, checks the result of the previous read first
  task automatic put_read(input logic en);
    if (rd_pending) begin
      check("rd_data", 32'(rd_expect), 32'(rd_data));
      last_read  = rd_expect;
      rd_pending = 1'b0;
    end
    rd_en = en;
    if (en && !empty) begin
      if (model.size() == 0) begin
        $display("Error in %s: DUT accepted a read with no word left in the model",
                 cur_test);
        errors++;
      end else begin
        rd_expect  = model.pop_front();
        rd_pending = 1'b1;
        rd_count++;
      end
    end
  endtask

  task automatic report_test(input int errors_before);
    if (errors == errors_before) $display("%s: ok", cur_test);
    else $display("%s: %0d errors", cur_test, errors - errors_before);
  endtask

  task automatic test_reset_flags();
    int e0;
    cur_test = "test_reset_flags";
    e0 = errors;
    @(negedge wr_clk);
    check("full", 0, 32'(full));
    check("afull", 0, 32'(afull));
    check("empty", 1, 32'(empty));
    check("aempty", 1, 32'(aempty));
    check("rd_data", 0, 32'(rd_data));
    report_test(e0);
  endtask

  task automatic test_write_read_order();
    int e0;
    int n;
    int rd_start;
    cur_test = "test_write_read_order";
    e0 = errors;
    for (int i = 0; i < 5; i++) begin
      @(negedge wr_clk);
      put_write(1'b1, data_t'($random(seed)));
    end
    @(negedge wr_clk);
    put_write(1'b0, '0);
    wait_flag("empty", 1'b0, 10);
    // Later words may still be in the synchronizer, so retry until five are taken
    rd_start = rd_count;
    n = 0;
    while (rd_count - rd_start < 5 && n < 30) begin
      @(negedge rd_clk);
      put_read(1'b1);
      n++;
    end
    @(negedge rd_clk);
    put_read(1'b0);
    check("words read", 5, 32'(rd_count - rd_start));
    wait_flag("empty", 1'b1, 10);
    check("model size", 0, 32'(model.size()));
    report_test(e0);
  endtask

  task automatic test_fill_full();
    int e0;
    cur_test = "test_fill_full";
    e0 = errors;
    wait_flag("afull", 1'b0, 10);
    // The last of these is the extra write into a full FIFO
    for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
      @(negedge wr_clk);
      check("afull", 32'(model.size() >= FIFO_AFULL), 32'(afull));
      check("full", 32'(model.size() == FIFO_DEPTH), 32'(full));
      put_write(1'b1, data_t'($random(seed)));
    end
    @(negedge wr_clk);
    put_write(1'b0, '0);
    check("full", 1, 32'(full));
    check("afull", 1, 32'(afull));
    check("model size", FIFO_DEPTH, 32'(model.size()));
    report_test(e0);
  endtask

  task automatic test_drain_empty();
    int  e0;
    bit  done;
    cur_test = "test_drain_empty";
    e0 = errors;
    done = 1'b0;
    for (int n = 0; n < 40 && !done; n++) begin
      @(negedge rd_clk);
      check("aempty", 32'(model.size() <= FIFO_AEMPTY), 32'(aempty));
      check("empty", 32'(model.size() == 0), 32'(empty));
      done = empty;
      put_read(1'b1);  // Still strobed once empty is seen
    end
    if (!done) begin
      $display("Timeout in %s: empty never came back while draining", cur_test);
      errors++;
    end
    @(negedge rd_clk);
    put_read(1'b0);
    check("rd_data hold", 32'(last_read), 32'(rd_data));
    check("model size", 0, 32'(model.size()));
    wait_flag("full", 1'b0, 10);
    wait_flag("afull", 1'b0, 10);
    report_test(e0);
  endtask

  task automatic test_stream_random();
    int          e0;
    bit          done;
    logic [31:0] r;
    logic [31:0] q;
    cur_test = "test_stream_random";
    e0 = errors;
    fork
      begin
        for (int i = 0; i < 200; i++) begin
          @(negedge wr_clk);
          r = $random(seed);
          put_write(r[0], data_t'($random(seed)));
        end
        @(negedge wr_clk);
        put_write(1'b0, '0);
      end
      begin
        for (int i = 0; i < 200; i++) begin
          @(negedge rd_clk);
          q = $random(rd_seed);
          put_read(q[0]);
        end
      end
    join
    // All writes have crossed by now, so empty stays once it is seen
    done = 1'b0;
    for (int n = 0; n < 80 && !done; n++) begin
      @(negedge rd_clk);
      done = empty;
      put_read(!done);
    end
    if (!done) begin
      $display("Timeout in %s: FIFO did not drain after the random stream", cur_test);
      errors++;
    end
    check("model size at empty", 0, 32'(model.size()));
    report_test(e0);
  endtask

  initial begin
    rst_n   = 1'b0;
    wr_en   = 1'b0;
    rd_en   = 1'b0;
    wr_data = '0;
    rd_seed = seed ^ 32'h1357;
    repeat (4) @(posedge wr_clk);
    #10 rst_n = 1'b1;  // Clear of both clock edges
    test_reset_flags();
    test_write_read_order();
    test_fill_full();
    test_drain_empty();
    test_stream_random();
    $display("Tests run: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* async_fifo.sv */
`timescale 1ns/1ps

module async_fifo (
  input  logic            wr_clk ,
  input  logic            rd_clk ,
  input  logic            rst_n  ,
  input  logic            wr_en  ,
  input  logic            rd_en  ,
  input  fifo_pkg::data_t wr_data,
  output fifo_pkg::data_t rd_data,
  output logic            full   ,
  output logic            empty  ,
  output logic            afull  ,
  output logic            aempty
);

  import fifo_pkg::*;

  // Write domain
  logic  wr_vld;
  addr_t wr_addr;
  ptr_t  wr_gray;
  ptr_t  rd_gray_wsyn;

  // Read domain
  logic  rd_vld;
  addr_t rd_addr;
  ptr_t  rd_gray;
  ptr_t  wr_gray_rsyn;

  fifo_wr_ctrl wr_ctrl0 (
    .wr_clk       (wr_clk      ),
    .rst_n        (rst_n       ),
    .wr_en        (wr_en       ),
    .rd_gray_wsyn (rd_gray_wsyn),
    .wr_vld       (wr_vld      ),
    .wr_addr      (wr_addr     ),
    .wr_gray      (wr_gray     ),
    .full         (full        ),
    .afull        (afull       )
  );

  fifo_rd_ctrl rd_ctrl0 (
    .rd_clk       (rd_clk      ),
    .rst_n        (rst_n       ),
    .rd_en        (rd_en       ),
    .wr_gray_rsyn (wr_gray_rsyn),
    .rd_vld       (rd_vld      ),
    .rd_addr      (rd_addr     ),
    .rd_gray      (rd_gray     ),
    .empty        (empty       ),
    .aempty       (aempty      )
  );

  // Write pointer into rd_clk
  gray_ptr_sync wr2rd_sync0 (
    .clk      (rd_clk      ),
    .rst_n    (rst_n       ),
    .gray_in  (wr_gray     ),
    .gray_out (wr_gray_rsyn)
  );

  // Read pointer into wr_clk
  gray_ptr_sync rd2wr_sync0 (
    .clk      (wr_clk      ),
    .rst_n    (rst_n       ),
    .gray_in  (rd_gray     ),
    .gray_out (rd_gray_wsyn)
  );

  dualport_ram_async ram0 (
    .wr_clk  (wr_clk ),
    .wr_en   (wr_vld ),  // Qualified with full
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_clk  (rd_clk ),
    .rst_n   (rst_n  ),
    .rd_en   (rd_vld ),  // Qualified with empty
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

/* fifo_rd_ctrl.sv */
`timescale 1ns/1ps

module fifo_rd_ctrl (
  input  logic            rd_clk      ,
  input  logic            rst_n       ,
  input  logic            rd_en       ,
  input  fifo_pkg::ptr_t  wr_gray_rsyn,
  output logic            rd_vld      ,
  output fifo_pkg::addr_t rd_addr     ,
  output fifo_pkg::ptr_t  rd_gray     ,
  output logic            empty       ,
  output logic            aempty
);

  import fifo_pkg::*;

  ptr_t rd_ptr;       // Binary read pointer
  ptr_t rd_ptr_nxt;
  ptr_t wr_ptr_rsyn;  // Write pointer seen from this side
  ptr_t fill_nxt;

  // Reads from an empty FIFO are ignored
  assign rd_vld     = rd_en && !empty;
  assign rd_ptr_nxt = rd_ptr + ptr_t'(rd_vld);
  assign rd_addr    = rd_ptr[ADDR_WIDTH-1:0];

  assign wr_ptr_rsyn = gray2bin(wr_gray_rsyn);

  // Words left after this edge
  assign fill_nxt = wr_ptr_rsyn - rd_ptr_nxt;

  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr  <= '0;
      rd_gray <= '0;
    end else begin
      rd_ptr  <= rd_ptr_nxt;
      rd_gray <= bin2gray(rd_ptr_nxt);
    end
  end

  // Writes arrive through the synchronizer a few cycles late,
  // which keeps empty on the safe side
  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= (fill_nxt == '0);
      aempty <= (fill_nxt <= ptr_t'(FIFO_AEMPTY));  // Includes empty
    end
  end

endmodule

/* fifo_wr_ctrl.sv */
`timescale 1ns/1ps

module fifo_wr_ctrl (
  input  logic            wr_clk      ,
  input  logic            rst_n       ,
  input  logic            wr_en       ,
  input  fifo_pkg::ptr_t  rd_gray_wsyn,
  output logic            wr_vld      ,
  output fifo_pkg::addr_t wr_addr     ,
  output fifo_pkg::ptr_t  wr_gray     ,
  output logic            full        ,
  output logic            afull
);

  import fifo_pkg::*;

  ptr_t wr_ptr;       // Binary write pointer
  ptr_t wr_ptr_nxt;
  ptr_t rd_ptr_wsyn;  // Read pointer seen from this side
  ptr_t fill_nxt;

  // Writes into a full FIFO are dropped here
  assign wr_vld     = wr_en && !full;
  assign wr_ptr_nxt = wr_ptr + ptr_t'(wr_vld);
  assign wr_addr    = wr_ptr[ADDR_WIDTH-1:0];

  assign rd_ptr_wsyn = gray2bin(rd_gray_wsyn);

  // Wraps correctly thanks to the extra pointer bit
  assign fill_nxt = wr_ptr_nxt - rd_ptr_wsyn;

  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      wr_gray <= '0;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      wr_gray <= bin2gray(wr_ptr_nxt);  // Registered before crossing
    end
  end

  // Flags follow the write at the same edge
  // Reads show up late, so these only err towards full
  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (fill_nxt == ptr_t'(FIFO_DEPTH));
      afull <= (fill_nxt >= ptr_t'(FIFO_AFULL));
    end
  end

endmodule

/* gray_ptr_sync.sv */
`timescale 1ns/1ps

module gray_ptr_sync (
  input  logic           clk     ,  // Destination clock
  input  logic           rst_n   ,
  input  fifo_pkg::ptr_t gray_in ,
  output fifo_pkg::ptr_t gray_out
);

  import fifo_pkg::*;

  ptr_t gray_meta;  // First stage, may go metastable

  // Only one bit moves per pointer step, so a sample taken
  // mid-change settles to either the old or the new pointer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gray_meta <= '0;
      gray_out  <= '0;
    end else begin
      gray_meta <= gray_in;
      gray_out  <= gray_meta;
    end
  end

endmodule

/* dualport_ram_async.sv */
`timescale 1ns/1ps

module dualport_ram_async (
  input  logic             wr_clk ,
  input  logic             wr_en  ,
  input  fifo_pkg::addr_t  wr_addr,
  input  fifo_pkg::data_t  wr_data,
  input  logic             rd_clk ,
  input  logic             rst_n  ,
  input  logic             rd_en  ,
  input  fifo_pkg::addr_t  rd_addr,
  output fifo_pkg::data_t  rd_data
);

  import fifo_pkg::*;

  data_t mem [FIFO_DEPTH];

  // Write port
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port, registered in the read domain
  // Holds its last word when no read is accepted
  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* fifo_pkg.sv */
package fifo_pkg;

  // Storage geometry
  localparam int DATA_WIDTH  = 8;
  localparam int FIFO_DEPTH  = 16;
  localparam int ADDR_WIDTH  = $clog2(FIFO_DEPTH);

  // Flag thresholds in words
  localparam int FIFO_AFULL  = FIFO_DEPTH - 1;  // Write-side count
  localparam int FIFO_AEMPTY = 1;               // Read-side count

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // Address plus one wrap bit so full and empty differ
  typedef logic [ADDR_WIDTH:0]   ptr_t;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // Walk down from the MSB, each bit folds in the one above
  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[ADDR_WIDTH] = gray[ADDR_WIDTH];
    for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage
